// ==== hw/lcdPkg.sv ====
`default_nettype none

package lcdPkg;

	// panel size in pixels, portrait orientation
	localparam int ScreenWidth = 240;
	localparam int ScreenHeight = 320;

	// character and coin are both square sprites
	localparam int SpriteSize = 20;
	// background tile, repeated over the whole screen
	localparam int TileSize = 80;

	// controller commands used by the cursor-home sequence
	localparam logic [15:0] CmdColumnAddr = 16'h002A;
	localparam logic [15:0] CmdPageAddr = 16'h002B;
	localparam logic [15:0] CmdMemWrite = 16'h002C;

	// sprite colours, rgb565
	localparam logic [15:0] ColorBoth = 16'h0000;
	localparam logic [15:0] ColorChar = 16'hF0FF;
	localparam logic [15:0] ColorCoin = 16'h00AA;

	// column cmd, two args, page cmd, two args, memory write
	localparam int CursorWords = 7;
	// 80 x 80 texels fit in 13 bits
	localparam int BgAddrWidth = 13;

	// parallel panel bus, all strobes active low except rs
	typedef struct packed {
		logic [15:0] d;
		logic wrN;
		logic rdN;
		logic csN;
		logic resetN;
		logic rs;
	} lcdBus_t;

	// one word for the panel, rs low marks a command
	typedef struct packed {
		logic rs;
		logic [15:0] data;
	} lcdWord_t;

	typedef logic [10:0] coord_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
	} position_t;

	typedef struct packed {
		logic signed [15:0] x;
		logic signed [15:0] y;
	} velocity_t;

	// sequencer output, either a ready-made command word or a pixel position
	typedef struct packed {
		logic isPixel;
		lcdWord_t word;
		position_t pos;
	} seqItem_t;

endpackage

`default_nettype wire

// ==== hw/panelArbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module panelArbiter (
	input wire clk,
	input wire rst,
	input wire lcdPkg::lcdBus_t cpuBus,
	input wire bufferMode,
	input wire lcdPkg::lcdBus_t engineBus,
	output lcdPkg::lcdBus_t screen,
	output logic engineActive
);

	import lcdPkg::*;

	// cpu writes the memory-write command to the panel
	logic memWriteSeen;

	assign memWriteSeen = (cpuBus.d == CmdMemWrite) && !cpuBus.rs && !cpuBus.csN;

	// ownership flag, bufferMode decides take or release
	always_ff @(posedge clk)
	begin
		if (rst)
			engineActive <= 1'b0;
		else if (memWriteSeen)
			engineActive <= bufferMode;
	end

	// panel bus select, purely combinational so cpu mode has no latency
	always_comb
	begin
		// panel reset always stays with the cpu
		screen = cpuBus;
		if (engineActive)
		begin
			screen.d = engineBus.d;
			screen.rs = engineBus.rs;
			screen.csN = engineBus.csN;
			screen.wrN = engineBus.wrN;
			// the engine never reads the panel
			screen.rdN = 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hw/frameSequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module frameSequencer (
	input wire clk,
	input wire rst,
	input wire engineActive,
	input wire seqReady,
	output lcdPkg::seqItem_t seq,
	output logic seqValid
);

	import lcdPkg::*;

	// low while the cursor-home words go out, high for the pixel sweep
	logic pixelPhase;
	logic [2:0] cursorIdx;
	coord_t x;
	coord_t y;
	logic advance;

	// an item is always on offer while the engine owns the panel
	assign seqValid = engineActive;
	assign advance = seqValid && seqReady;

	always_ff @(posedge clk)
	begin
		if (rst || !engineActive)
		begin
			pixelPhase <= 1'b0;
			cursorIdx <= '0;
			x <= '0;
			y <= '0;
		end
		else if (advance)
		begin
			if (!pixelPhase)
			begin
				// last cursor word done, start the sweep at (0,0)
				if (cursorIdx == 3'(CursorWords - 1))
				begin
					pixelPhase <= 1'b1;
					cursorIdx <= '0;
				end
				else
					cursorIdx <= cursorIdx + 3'd1;
			end
			else if (x == coord_t'(ScreenWidth - 1))
			begin
				x <= '0;
				// end of frame, go back to the cursor sequence
				if (y == coord_t'(ScreenHeight - 1))
				begin
					y <= '0;
					pixelPhase <= 1'b0;
				end
				else
					y <= y + coord_t'(1);
			end
			else
				x <= x + coord_t'(1);
		end
	end

	// item contents, the word only matters for commands
	always_comb
	begin
		seq.isPixel = pixelPhase;
		seq.pos.x = x;
		seq.pos.y = y;
		case (cursorIdx)
			3'd0: seq.word = '{rs: 1'b0, data: CmdColumnAddr};
			3'd3: seq.word = '{rs: 1'b0, data: CmdPageAddr};
			3'd6: seq.word = '{rs: 1'b0, data: CmdMemWrite};
			// start and end arguments, all zero
			default: seq.word = '{rs: 1'b1, data: 16'h0000};
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/pixelShader.sv ====
`timescale 1ns/1ns
`default_nettype none

module pixelShader (
	input wire clk,
	input wire rst,
	input wire engineActive,
	input wire lcdPkg::seqItem_t seq,
	input wire seqValid,
	output logic seqReady,
	output lcdPkg::lcdWord_t word,
	output logic wordValid,
	input wire wordReady,
	input wire lcdPkg::position_t charPos,
	input wire lcdPkg::position_t coinPos,
	output logic [lcdPkg::BgAddrWidth-1:0] wbAdr,
	output logic wbCyc,
	output logic wbStb,
	input wire [15:0] wbDatIn,
	input wire wbAck,
	output logic overlap
);

	import lcdPkg::*;

	typedef enum logic [1:0] {Idle, Fetch, Hold} state_t;

	state_t state;
	lcdWord_t wordReg;
	// pixel being shaded, kept for the containment tests
	position_t posReg;
	logic takeSeq;
	logic [BgAddrWidth-1:0] bgAddr;
	logic inChar;
	logic inCoin;
	logic [15:0] pixelColor;

	// one item at a time, a new one may enter as the held word leaves
	assign seqReady = !wbCyc && (state == Idle || (state == Hold && wordReady));
	assign takeSeq = seqValid && seqReady;
	assign wordValid = (state == Hold);
	assign word = wordReg;
	assign wbStb = wbCyc;

	// tile repeats every 80 pixels in both directions
	assign bgAddr = BgAddrWidth'(seq.pos.x % TileSize)
		+ BgAddrWidth'(TileSize) * BgAddrWidth'(seq.pos.y % TileSize);

	// half-open 20 x 20 squares at the sprite positions
	assign inChar = (posReg.x >= charPos.x) && (posReg.x < charPos.x + SpriteSize)
		&& (posReg.y >= charPos.y) && (posReg.y < charPos.y + SpriteSize);
	assign inCoin = (posReg.x >= coinPos.x) && (posReg.x < coinPos.x + SpriteSize)
		&& (posReg.y >= coinPos.y) && (posReg.y < coinPos.y + SpriteSize);

	always_comb
	begin
		case ({inChar, inCoin})
			2'b11: pixelColor = ColorBoth;
			2'b10: pixelColor = ColorChar;
			2'b01: pixelColor = ColorCoin;
			default: pixelColor = wbDatIn;
		endcase
	end

	// one pulse per emitted pixel inside both sprites
	assign overlap = (state == Fetch) && wbAck && inChar && inCoin;

	always_ff @(posedge clk)
	begin
		if (rst || !engineActive)
			state <= Idle;
		else if (takeSeq)
			state <= seq.isPixel ? Fetch : Hold;
		else if (state == Fetch && wbAck)
			state <= Hold;
		else if (state == Hold && wordReady)
			state <= Idle;
	end

	// a read already on the bus runs to its ack even after release
	always_ff @(posedge clk)
	begin
		if (rst)
			wbCyc <= 1'b0;
		else if (wbCyc)
		begin
			if (wbAck)
				wbCyc <= 1'b0;
		end
		else if (takeSeq && seq.isPixel)
			wbCyc <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (takeSeq)
		begin
			// commands go straight through, pixels wait for the texel
			wordReg <= seq.word;
			posReg <= seq.pos;
			wbAdr <= bgAddr;
		end
		else if (state == Fetch && wbAck)
			wordReg <= '{rs: 1'b1, data: pixelColor};
	end

endmodule

`default_nettype wire

// ==== hw/spriteMotion.sv ====
`timescale 1ns/1ns
`default_nettype none

module spriteMotion #(
	parameter int unsigned MoveTickCycles = 1 << 20
) (
	input wire clk,
	input wire rst,
	input wire engineActive,
	input wire lcdPkg::velocity_t charVel,
	input wire lcdPkg::velocity_t coinVel,
	input wire lcdPkg::position_t coinStart,
	input wire overlap,
	output lcdPkg::position_t charPos,
	output lcdPkg::position_t coinPos,
	output logic hit
);

	import lcdPkg::*;

	localparam int TickWidth = $clog2(MoveTickCycles + 1);

	logic [TickWidth-1:0] tickCnt;
	logic tick;

	// character axis, stops against the screen edge
	function automatic coord_t clampAxis(input coord_t pos, input logic signed [15:0] vel,
		input int limit);
		logic signed [16:0] sum;
		sum = $signed({6'b0, pos}) + vel;
		if (sum < 0)
			return '0;
		else if (sum > limit)
			return coord_t'(limit);
		else
			return coord_t'(sum);
	endfunction

	// coin axis, leaves one edge and comes back at the other
	function automatic coord_t wrapAxis(input coord_t pos, input logic signed [15:0] vel,
		input int limit);
		logic signed [16:0] sum;
		sum = $signed({6'b0, pos}) + vel;
		if (sum < 1)
			return coord_t'(limit);
		else if (sum >= limit)
			return coord_t'(SpriteSize + 1);
		else
			return coord_t'(sum);
	endfunction

	// free-running movement tick, counted from reset
	assign tick = (tickCnt == TickWidth'(MoveTickCycles - 1));

	always_ff @(posedge clk)
	begin
		if (rst || tick)
			tickCnt <= '0;
		else
			tickCnt <= tickCnt + TickWidth'(1);
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			charPos.x <= coord_t'(10);
			charPos.y <= coord_t'(10);
		end
		else if (tick)
		begin
			charPos.x <= clampAxis(charPos.x, charVel.x, ScreenWidth - SpriteSize);
			charPos.y <= clampAxis(charPos.y, charVel.y, ScreenHeight - SpriteSize);
		end
	end

	// coin restarts from coinStart whenever the cpu has the panel
	always_ff @(posedge clk)
	begin
		if (rst || !engineActive)
			coinPos <= coinStart;
		else if (tick)
		begin
			coinPos.x <= wrapAxis(coinPos.x, coinVel.x, ScreenWidth - SpriteSize);
			coinPos.y <= wrapAxis(coinPos.y, coinVel.y, ScreenHeight - SpriteSize);
		end
	end

	// sticky collision flag for the running game
	always_ff @(posedge clk)
	begin
		if (rst || !engineActive)
			hit <= 1'b0;
		else if (overlap)
			hit <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== hw/lcdWriter.sv ====
`timescale 1ns/1ns
`default_nettype none

module lcdWriter (
	input wire clk,
	input wire rst,
	input wire engineActive,
	input wire lcdPkg::lcdWord_t word,
	input wire wordValid,
	output logic wordReady,
	output lcdPkg::lcdBus_t engineBus
);

	import lcdPkg::*;

	// strobe is the cycle with csN and wrN low, recover the high cycle after it
	logic strobe;
	logic recover;
	lcdWord_t wordReg;

	// busy for both phases, so at most one word per two cycles
	assign wordReady = !strobe && !recover;

	always_ff @(posedge clk)
	begin
		if (rst || !engineActive)
		begin
			strobe <= 1'b0;
			recover <= 1'b0;
		end
		else
		begin
			strobe <= wordValid && wordReady;
			recover <= strobe;
		end
	end

	// data is presented together with the strobe
	always_ff @(posedge clk)
	begin
		if (wordValid && wordReady)
			wordReg <= word;
	end

	always_comb
	begin
		engineBus.d = wordReg.data;
		engineBus.rs = wordReg.rs;
		engineBus.csN = !strobe;
		engineBus.wrN = !strobe;
		// the arbiter replaces these two
		engineBus.rdN = 1'b1;
		engineBus.resetN = 1'b1;
	end

endmodule

`default_nettype wire

// ==== hw/lcdStreamer.sv ====
`timescale 1ns/1ns
`default_nettype none

module lcdStreamer #(
	parameter int unsigned MoveTickCycles = 1 << 20
) (
	input wire clk,
	input wire rst,
	input wire lcdPkg::lcdBus_t cpuBus,
	input wire bufferMode,
	input wire lcdPkg::velocity_t charVel,
	input wire lcdPkg::velocity_t coinVel,
	input wire lcdPkg::position_t coinStart,
	output lcdPkg::lcdBus_t screen,
	output logic [lcdPkg::BgAddrWidth-1:0] wbAdr,
	output logic wbCyc,
	output logic wbStb,
	input wire [15:0] wbDatIn,
	input wire wbAck,
	output lcdPkg::position_t charPos,
	output logic hit
);

	import lcdPkg::*;

	logic engineActive;
	// stage 1 to stage 2
	seqItem_t seq;
	logic seqValid;
	logic seqReady;
	// stage 2 to stage 3
	lcdWord_t word;
	logic wordValid;
	logic wordReady;
	lcdBus_t engineBus;
	position_t coinPos;
	logic overlap;

	panelArbiter arbiter (
		.clk(clk),
		.rst(rst),
		.cpuBus(cpuBus),
		.bufferMode(bufferMode),
		.engineBus(engineBus),
		.screen(screen),
		.engineActive(engineActive)
	);

	frameSequencer sequencer (
		.clk(clk),
		.rst(rst),
		.engineActive(engineActive),
		.seqReady(seqReady),
		.seq(seq),
		.seqValid(seqValid)
	);

	pixelShader shader (
		.clk(clk),
		.rst(rst),
		.engineActive(engineActive),
		.seq(seq),
		.seqValid(seqValid),
		.seqReady(seqReady),
		.word(word),
		.wordValid(wordValid),
		.wordReady(wordReady),
		.charPos(charPos),
		.coinPos(coinPos),
		.wbAdr(wbAdr),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbDatIn(wbDatIn),
		.wbAck(wbAck),
		.overlap(overlap)
	);

	spriteMotion #(
		.MoveTickCycles(MoveTickCycles)
	) motion (
		.clk(clk),
		.rst(rst),
		.engineActive(engineActive),
		.charVel(charVel),
		.coinVel(coinVel),
		.coinStart(coinStart),
		.overlap(overlap),
		.charPos(charPos),
		.coinPos(coinPos),
		.hit(hit)
	);

	lcdWriter writer (
		.clk(clk),
		.rst(rst),
		.engineActive(engineActive),
		.word(word),
		.wordValid(wordValid),
		.wordReady(wordReady),
		.engineBus(engineBus)
	);

endmodule

`default_nettype wire

// ==== test/lcdStreamer_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module lcdStreamerProperties (
	input wire clk,
	input wire rst,
	input wire engineActive,
	input wire lcdPkg::lcdBus_t screen,
	input wire [lcdPkg::BgAddrWidth-1:0] wbAdr,
	input wire wbCyc,
	input wire wbStb,
	input wire wbAck,
	input wire hit
);

	// classic wishbone, stb only inside a cycle
	stbInsideCyc: assert property (@(posedge clk) disable iff (rst) wbStb |-> wbCyc)
		else $error("wishbone stb raised without cyc");

	// request and address stay put until the slave acks
	requestHeld: assert property (@(posedge clk) disable iff (rst)
		(wbCyc && !wbAck) |=> (wbCyc && $stable(wbAdr)))
		else $error("wishbone cyc or address changed before ack");

	// engine never reads from the panel
	noReadInEngine: assert property (@(posedge clk) disable iff (rst)
		engineActive |-> screen.rdN)
		else $error("panel rdN low while the engine owns the panel");

	hitClearAfterReset: assert property (@(posedge clk) rst |=> !hit)
		else $error("hit flag set in the cycle after reset");

endmodule

bind lcdStreamer lcdStreamerProperties props (
	.clk(clk),
	.rst(rst),
	.engineActive(engineActive),
	.screen(screen),
	.wbAdr(wbAdr),
	.wbCyc(wbCyc),
	.wbStb(wbStb),
	.wbAck(wbAck),
	.hit(hit)
);

`default_nettype wire

// ==== test/lcdStreamerTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module lcdStreamerTb;

	import lcdPkg::*;

	localparam int RecWords = 6;
	localparam int MaxRecords = 16;
	// slowest pixel is two cycles plus three wait cycles
	localparam longint FrameCycles = longint'(ScreenWidth * ScreenHeight + CursorWords) * 5;
	localparam logic [31:0] Seed = 32'h9235_65e6;
	localparam lcdBus_t IdleBus = '{d: 16'h0000, wrN: 1'b1, rdN: 1'b1, csN: 1'b1,
		resetN: 1'b1, rs: 1'b1};

	logic clk;
	logic rst;
	lcdBus_t cpuBus;
	logic bufferMode;
	velocity_t charVel;
	velocity_t coinVel;
	position_t coinStart;
	lcdBus_t screen;
	logic [BgAddrWidth-1:0] wbAdr;
	logic wbCyc;
	logic wbStb;
	logic [15:0] wbDatIn;
	logic wbAck;
	position_t charPos;
	logic hit;

	logic [31:0] vectors [0:MaxRecords*RecWords-1];
	int errors;
	int checks;
	longint cycles;
	longint cycleLimit;
	logic [31:0] lfsr;
	// wishbone slave model state
	logic busy;
	int waitLeft;
	position_t prevChar;
	// velocity the DUT sees at the next rising edge
	velocity_t prevVel;

	lcdStreamer #(
		.MoveTickCycles(3000)
	) uut (
		.clk(clk),
		.rst(rst),
		.cpuBus(cpuBus),
		.bufferMode(bufferMode),
		.charVel(charVel),
		.coinVel(coinVel),
		.coinStart(coinStart),
		.screen(screen),
		.wbAdr(wbAdr),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbDatIn(wbDatIn),
		.wbAck(wbAck),
		.charPos(charPos),
		.hit(hit)
	);

	initial
		clk = 1'b0;
	always #20 clk = ~clk;

	// fibonacci lfsr, taps 32 22 2 1
	task automatic takeBit(output logic b);
		lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
		b = lfsr[0];
	endtask

	task automatic randomBits(input int n, output logic [31:0] v);
		logic b;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			takeBit(b);
			v = {v[30:0], b};
		end
	endtask

	// character axis rule, stop at 0 and at the screen size minus the sprite
	function automatic coord_t clampExpect(input coord_t p, input logic signed [15:0] v,
		input int limit);
		int n;
		n = int'(p) + int'(v);
		if (n < 0)
			n = 0;
		if (n > limit)
			n = limit;
		return coord_t'(n);
	endfunction

	function automatic logic inSquare(input int x, input int y, input int sx, input int sy);
		return (x >= sx) && (x < sx + SpriteSize) && (y >= sy) && (y < sy + SpriteSize);
	endfunction

	// containment rule, character parked at its home (10,10)
	function automatic logic [15:0] expectColor(input int x, input int y, input position_t coin);
		logic inC;
		logic inK;
		int addr;
		inC = inSquare(x, y, 10, 10);
		inK = inSquare(x, y, int'(coin.x), int'(coin.y));
		addr = (x % TileSize) + TileSize * (y % TileSize);
		if (inC && inK)
			return ColorBoth;
		else if (inC)
			return ColorChar;
		else if (inK)
			return ColorCoin;
		else
			return 16'(addr) ^ 16'h5A5A;
	endfunction

	// memory model, 0 to 3 wait states, data is address xor 5a5a
	always @(posedge clk)
	begin
		logic [31:0] w;
		#2;
		if (wbAck)
		begin
			wbAck = 1'b0;
			busy = 1'b0;
		end
		else
		begin
			if (wbCyc && wbStb && !busy)
			begin
				busy = 1'b1;
				randomBits(2, w);
				waitLeft = int'(w);
			end
			if (busy)
			begin
				if (waitLeft == 0)
				begin
					wbAck = 1'b1;
					wbDatIn = {3'b000, wbAdr} ^ 16'h5A5A;
				end
				else
					waitLeft--;
			end
		end
	end

	// every move of the character follows the velocity and clamp rule
	always @(negedge clk)
	begin
		if (!rst)
		begin
			if (charPos !== prevChar)
			begin
				checks++;
				assert (charPos.x == clampExpect(prevChar.x, prevVel.x, ScreenWidth - SpriteSize)
					&& charPos.y == clampExpect(prevChar.y, prevVel.y,
					ScreenHeight - SpriteSize))
				else
				begin
					errors++;
					$display("ERR charPos: got %h expected from %h plus %h", charPos, prevChar,
						prevVel);
				end
			end
		end
		prevChar = charPos;
		prevVel = charVel;
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycleLimit > 0 && cycles > cycleLimit)
		begin
			errors++;
			$display("timeout: run still busy after %0d cycles", cycles);
			$display("checks: %0d, errors: %0d", checks, errors);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	task automatic nextDriveSlot;
		@(posedge clk);
		#2;
	endtask

	// cpu mode, random bus words must reach the panel unchanged
	task automatic verifyPassThrough(input int n);
		logic [31:0] v;
		for (int i = 0; i < n; i++)
		begin
			nextDriveSlot();
			randomBits(21, v);
			cpuBus = lcdBus_t'(v[20:0]);
			// upper data byte set, so never the memory-write command
			cpuBus.d[8] = 1'b1;
			@(negedge clk);
			checks++;
			assert (screen === cpuBus)
			else
			begin
				errors++;
				$display("ERR screen: got %h expected %h", screen, cpuBus);
			end
			assert (wbCyc === 1'b0)
			else
			begin
				errors++;
				$display("ERR wbCyc: got %h expected 0", wbCyc);
			end
			assert (wbStb === 1'b0)
			else
			begin
				errors++;
				$display("ERR wbStb: got %h expected 0", wbStb);
			end
		end
		nextDriveSlot();
		cpuBus = IdleBus;
	endtask

	// next strobed panel word, checking rdN and resetN on the way
	task automatic waitStrobe(output lcdWord_t w);
		logic seen;
		seen = 1'b0;
		while (!seen)
		begin
			@(negedge clk);
			assert (screen.rdN === 1'b1 && screen.resetN === cpuBus.resetN)
			else
			begin
				errors++;
				$display("ERR screen.rdN/resetN: got %h/%h expected 1/%h", screen.rdN,
					screen.resetN, cpuBus.resetN);
			end
			if (screen.csN === 1'b0 && screen.wrN === 1'b0)
				seen = 1'b1;
		end
		w = '{rs: screen.rs, data: screen.d};
	endtask

	task automatic matchCursor;
		lcdWord_t w;
		lcdWord_t e;
		for (int i = 0; i < CursorWords; i++)
		begin
			waitStrobe(w);
			case (i)
				0: e = '{rs: 1'b0, data: CmdColumnAddr};
				3: e = '{rs: 1'b0, data: CmdPageAddr};
				6: e = '{rs: 1'b0, data: CmdMemWrite};
				default: e = '{rs: 1'b1, data: 16'h0000};
			endcase
			checks++;
			assert (w == e)
			else
			begin
				errors++;
				$display("ERR cursor word %0d {rs,d}: got %h expected %h", i, w, e);
			end
		end
	endtask

	task automatic scanFrame(input logic colours, input position_t coin);
		lcdWord_t w;
		logic [15:0] e;
		for (int y = 0; y < ScreenHeight; y++)
			for (int x = 0; x < ScreenWidth; x++)
			begin
				waitStrobe(w);
				e = expectColor(x, y, coin);
				checks++;
				assert (w.rs === 1'b1)
				else
				begin
					errors++;
					$display("ERR screen.rs pixel (%0d,%0d): got %h expected 1", x, y, w.rs);
				end
				if (colours)
					assert (w.data === e)
					else
					begin
						errors++;
						$display("ERR screen.d pixel (%0d,%0d): got %h expected %h", x, y,
							w.data, e);
					end
			end
	endtask

	initial
	begin
		int records;
		int frames;
		int base;
		logic expectHit;
		position_t charStart;
		rst = 1'b1;
		cpuBus = IdleBus;
		bufferMode = 1'b0;
		charVel = '0;
		coinVel = '0;
		coinStart = '0;
		wbAck = 1'b0;
		wbDatIn = '0;
		busy = 1'b0;
		waitLeft = 0;
		lfsr = Seed;
		errors = 0;
		checks = 0;
		cycles = 0;
		cycleLimit = 0;
		for (int i = 0; i < MaxRecords * RecWords; i++)
			vectors[i] = 32'hFFFF_FFFF;
		$readmemh("test/lcdStreamer_vectors.hex", vectors);
		records = 0;
		frames = 0;
		while (records < MaxRecords && vectors[records * RecWords] !== 32'hFFFF_FFFF)
		begin
			frames += int'(vectors[records * RecWords + 5]);
			records++;
		end
		cycleLimit = longint'(frames) * FrameCycles + 2000;

		repeat (3) @(posedge clk);
		#2;
		rst = 1'b0;
		verifyPassThrough(20);

		for (int r = 0; r < records; r++)
		begin
			base = r * RecWords;
			nextDriveSlot();
			// record word keeps d in bits 21:6 and the strobes in bits 4:0
			cpuBus = lcdBus_t'({vectors[base][21:6], vectors[base][4:0]});
			bufferMode = vectors[base + 1][0];
			charVel = velocity_t'(vectors[base + 2]);
			coinVel = velocity_t'(vectors[base + 3]);
			coinStart = position_t'(vectors[base + 4][21:0]);
			charStart = charPos;
			nextDriveSlot();
			cpuBus = IdleBus;
			if (bufferMode)
			begin
				matchCursor();
				for (int f = 0; f < int'(vectors[base + 5]); f++)
				begin
					// colours are only predictable for a parked character
					scanFrame(charVel == '0 && coinVel == '0, coinStart);
					matchCursor();
				end
				if (charVel == '0)
				begin
					// equal squares overlap when both offsets are below the side
					expectHit = int'(coinStart.x) > 10 - SpriteSize
						&& int'(coinStart.x) < 10 + SpriteSize
						&& int'(coinStart.y) > 10 - SpriteSize
						&& int'(coinStart.y) < 10 + SpriteSize;
					checks++;
					assert (hit === expectHit)
					else
					begin
						errors++;
						$display("ERR hit: got %h expected %h", hit, expectHit);
					end
				end
				else
				begin
					checks++;
					assert (charPos !== charStart)
					else
					begin
						errors++;
						$display("character never moved although its velocity is not zero");
					end
				end
			end
			else
			begin
				// let an open wishbone read finish
				@(negedge clk);
				while (wbCyc)
					@(negedge clk);
				repeat (2) @(negedge clk);
				checks++;
				assert (hit === 1'b0)
				else
				begin
					errors++;
					$display("ERR hit after release: got %h expected 0", hit);
				end
				verifyPassThrough(20);
			end
		end

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== lcdStreamer.f ====
hw/lcdPkg.sv
hw/panelArbiter.sv
hw/frameSequencer.sv
hw/pixelShader.sv
hw/spriteMotion.sv
hw/lcdWriter.sv
hw/lcdStreamer.sv
test/lcdStreamer_properties.sv
test/lcdStreamerTb.sv

// ==== Bender.yml ====
package:
  name: lcdStreamer

sources:
  - hw/lcdPkg.sv
  - hw/panelArbiter.sv
  - hw/frameSequencer.sv
  - hw/pixelShader.sv
  - hw/spriteMotion.sv
  - hw/lcdWriter.sv
  - hw/lcdStreamer.sv
  - target: test
    files:
      - test/lcdStreamer_properties.sv
      - test/lcdStreamerTb.sv

// ==== test/lcdStreamer_vectors.hex ====
// columns: cpuBus word, bufferMode, charVel {x,y}, coinVel {x,y}, coinStart {x,y}, frames
// cpuBus is {d, wrN, rdN, csN, resetN, rs}, coinStart packs x in bits 21:11 and y in 10:0
// take the panel, coin far from the character, full colour check
000B0A 1 00000000 00000000 00064118 1
// release
000B0A 0 00000000 00000000 00064118 0
// take again, coin at (15,15) overlaps the character at (10,10)
000B0A 1 00000000 00000000 0000780F 1
// release, hit must clear
000B0A 0 00000000 00000000 0000780F 0
// take with a moving character, x +3 and y -2 per tick
000B0A 1 0003FFFE 00000000 00064028 1
// final release
000B0A 0 00000000 00000000 00064028 0
